// ==== all.f ====
+incdir+hdl
hdl/bilin_fix_pkg.sv
hdl/bilin_ctl_pkg.sv
hdl/geom_if.sv
hdl/coord_gen.sv
hdl/tap_sequencer.sv
hdl/lane_blend.sv
hdl/bilinear_simd4.sv
dv/bilinear_simd4_sva.sv
dv/tb_bilinear_simd4.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_bilinear_simd4
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_bilinear_simd4.sv ====
`timescale 1ns/10ps

module tb_bilinear_simd4;
  import bilin_fix_pkg::*;

  localparam int NUM_CASES  = 4;
  localparam int MEM_DEPTH  = 1024;
  localparam int PX_CYCLES  = 40;
  localparam int EXTRA_CYC  = 1000;

  // One row of the test table
  typedef struct {
    int in_w;
    int in_h;
    int scale;
    int exp_w;
    int exp_h;
  } case_t;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  start;
  dim_t  in_w;
  dim_t  in_h;
  q88_t  scale;
  dim_t  out_w;
  dim_t  out_h;
  addr_t in_raddr;
  pix_t  in_rdata = '0;
  addr_t out_waddr;
  pix_t  out_wdata;
  logic  out_we;
  logic  busy;
  logic  done;
  cnt_t  rd_count;
  cnt_t  wr_count;

  case_t  cases   [NUM_CASES];
  pix_t   src_mem [MEM_DEPTH];
  pix_t   dst_mem [MEM_DEPTH];
  int     wr_hits [MEM_DEPTH];
  int     gold    [MEM_DEPTH];
  addr_t  rd_addr_q = '0;
  integer seed = 32'hcba9_d30d;
  int     errors = 0;
  int     stray_writes = 0;
  int     frame_px = 0;
  int     done_pulses = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  always #5 clk = ~clk;

  bilinear_simd4 UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_start        (start),
    .o_busy         (busy),
    .o_done         (done),
    .i_in_w         (in_w),
    .i_in_h         (in_h),
    .i_scale_q88    (scale),
    .o_out_w        (out_w),
    .o_out_h        (out_h),
    .o_in_raddr     (in_raddr),
    .i_in_rdata     (in_rdata),
    .o_out_waddr    (out_waddr),
    .o_out_wdata    (out_wdata),
    .o_out_we       (out_we),
    .o_mem_rd_count (rd_count),
    .o_mem_wr_count (wr_count)
  );

  // --------------------------------------------------
  // Memory models
  // --------------------------------------------------

  // Address seen at one falling edge returns data at the next
  always @(negedge clk) begin
    if (int'(rd_addr_q) < MEM_DEPTH) begin
      in_rdata <= src_mem[rd_addr_q];
    end else begin
      in_rdata <= '0;
    end
    rd_addr_q <= in_raddr;
  end

  // Destination capture, hit count per address
  always @(negedge clk) begin
    if (rst_n && out_we) begin
      if (int'(out_waddr) < frame_px) begin
        dst_mem[out_waddr] = out_wdata;
        wr_hits[out_waddr]++;
      end else begin
        stray_writes++;
      end
    end
    if (rst_n && done) begin
      done_pulses++;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input int got, input int expected);
    errors++;
    $display("[FAIL] %0t: %s, got %0d, expected %0d", $time, what, got, expected);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  // Input size, scale, expected output size
  task automatic load_cases;
    cases[0] = '{8, 6, 'h0100, 8, 6};
    cases[1] = '{10, 7, 'h0180, 15, 10};
    cases[2] = '{9, 5, 'h00C0, 6, 3};
    cases[3] = '{6, 4, 'h0200, 12, 8};
  endtask

  task automatic fill_source;
    int rnd;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      rnd = $random(seed);
      src_mem[i] = rnd[7:0];
    end
  endtask

  // --------------------------------------------------
  // Golden bilinear model
  // --------------------------------------------------
  task automatic compute_golden(input int w, input int h, input int sc);
    int inv;
    int ow;
    int oh;
    int sx;
    int sy;
    int bx;
    int by;
    int fx;
    int fy;
    int acc;
    inv = 65536 / sc;
    ow  = (w * sc) >> 8;
    oh  = (h * sc) >> 8;
    for (int oy = 0; oy < oh; oy++) begin
      // Q16.8 source row, pinned to the last interval at the bottom
      sy = (oy * inv) & 'hFF_FFFF;
      by = sy >> 8;
      fy = sy & 'hFF;
      if (by >= h - 1) begin
        by = h - 2;
        fy = 'hFF;
      end
      for (int ox = 0; ox < ow; ox++) begin
        sx = (ox * inv) & 'hFF_FFFF;
        bx = sx >> 8;
        fx = sx & 'hFF;
        if (bx >= w - 1) begin
          bx = w - 2;
          fx = 'hFF;
        end
        // Q0.16 weights times taps, plus half an LSB
        acc = (256 - fx) * (256 - fy) * src_mem[by * w + bx]
            + fx * (256 - fy) * src_mem[by * w + bx + 1]
            + (256 - fx) * fy * src_mem[(by + 1) * w + bx]
            + fx * fy * src_mem[(by + 1) * w + bx + 1]
            + 'h8000;
        gold[oy * ow + ox] = (acc >> 16) & 'hFF;
      end
    end
  endtask

  task automatic check_reset_state;
    if (busy !== 1'b0) report_mismatch("busy after reset", int'(busy), 0);
    if (done !== 1'b0) report_mismatch("done after reset", int'(done), 0);
    if (out_we !== 1'b0) report_mismatch("write enable after reset", int'(out_we), 0);
    if (rd_count !== '0) report_mismatch("read count after reset", int'(rd_count), 0);
    if (wr_count !== '0) report_mismatch("write count after reset", int'(wr_count), 0);
  endtask

  // --------------------------------------------------
  // One table row, start to done and all checks
  // --------------------------------------------------
  task automatic run_case(input int idx);
    case_t tc;
    int    done_before;
    tc = cases[idx];
    fill_source();
    compute_golden(tc.in_w, tc.in_h, tc.scale);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      dst_mem[i] = '0;
      wr_hits[i] = 0;
    end
    stray_writes = 0;
    frame_px     = tc.exp_w * tc.exp_h;
    done_before  = done_pulses;

    @(negedge clk);
    in_w  = dim_t'(tc.in_w);
    in_h  = dim_t'(tc.in_h);
    scale = q88_t'(tc.scale);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (busy !== 1'b0) report_mismatch("busy one cycle after start", int'(busy), 0);
    @(negedge clk);
    if (busy !== 1'b1) report_mismatch("busy two cycles after start", int'(busy), 1);
    // A second start while busy must be ignored
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;

    do @(negedge clk); while (done !== 1'b1);
    if (int'(out_w) != tc.exp_w) report_mismatch($sformatf("case %0d out_w", idx), out_w, tc.exp_w);
    if (int'(out_h) != tc.exp_h) report_mismatch($sformatf("case %0d out_h", idx), out_h, tc.exp_h);
    if (busy !== 1'b0) report_mismatch($sformatf("case %0d busy with done", idx), int'(busy), 0);
    repeat (3) @(negedge clk);

    if (done_pulses != done_before + 1) begin
      report_problem($sformatf("case %0d gave %0d done pulses instead of one",
                               idx, done_pulses - done_before));
    end
    for (int i = 0; i < frame_px; i++) begin
      if (wr_hits[i] != 1) begin
        report_mismatch($sformatf("case %0d writes to address %0d", idx, i), wr_hits[i], 1);
      end else if (int'(dst_mem[i]) != gold[i]) begin
        report_mismatch($sformatf("case %0d pixel (%0d,%0d)", idx, i % tc.exp_w, i / tc.exp_w),
                        dst_mem[i], gold[i]);
      end
    end
    if (stray_writes != 0) begin
      report_problem($sformatf("case %0d wrote %0d times outside the frame", idx, stray_writes));
    end
    if (int'(wr_count) != frame_px) begin
      report_mismatch($sformatf("case %0d write count", idx), wr_count, frame_px);
    end
    if (int'(rd_count) != 4 * frame_px) begin
      report_mismatch($sformatf("case %0d read count", idx), rd_count, 4 * frame_px);
    end
  endtask

  initial begin
    int total_px;
    int sva_fails;
    rst_n = 1'b0;
    start = 1'b0;
    in_w  = '0;
    in_h  = '0;
    scale = '0;
    load_cases();
    // Limit scales with the pixel count of the whole table
    total_px = 0;
    for (int c = 0; c < NUM_CASES; c++) begin
      total_px += cases[c].exp_w * cases[c].exp_h;
    end
    cycle_limit = PX_CYCLES * total_px + EXTRA_CYC;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();

    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end

    repeat (4) @(negedge clk);
    sva_fails = UUT.u_sva.assert_fails;
    $display("Errors: %0d failed checks, %0d failed assertions", errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/bilinear_simd4_sva.sv ====
`timescale 1ns/10ps

module bilinear_simd4_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 i_busy,
  input logic                 i_done,
  input logic                 i_out_we,
  input bilin_fix_pkg::addr_t i_out_waddr,
  input bilin_fix_pkg::dim_t  i_out_w,
  input bilin_fix_pkg::dim_t  i_out_h
);

  // Failed assertions so far, read by the testbench at the end of the run
  int          assert_fails = 0;
  // Pixels in the current output frame
  logic [31:0] frame_px;

  assign frame_px = i_out_w * i_out_h;

  // --------------------------------------------------
  // Control timing
  // --------------------------------------------------

  // Done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_done |=> !i_done)
    else begin
      assert_fails++;
      $error("done held high for more than one cycle");
    end

  // Writes only happen inside a frame
  a_we_busy: assert property (@(posedge clk) disable iff (!rst_n) i_out_we |-> i_busy)
    else begin
      assert_fails++;
      $error("write strobe while not busy");
    end

  // Busy has dropped once done is seen
  a_idle_after_done: assert property (@(posedge clk) disable iff (!rst_n) i_done |=> !i_busy)
    else begin
      assert_fails++;
      $error("busy still high after done");
    end

  // Write address stays inside the output frame
  a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    i_out_we |-> (32'(i_out_waddr) < frame_px))
    else begin
      assert_fails++;
      $error("write address outside the output frame");
    end

endmodule

bind bilinear_simd4 bilinear_simd4_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_busy      (o_busy),
  .i_done      (o_done),
  .i_out_we    (o_out_we),
  .i_out_waddr (o_out_waddr),
  .i_out_w     (o_out_w),
  .i_out_h     (o_out_h)
);

// ==== hdl/bilinear_simd4.sv ====
`timescale 1ns/10ps
`include "bilin_cfg.svh"

module bilinear_simd4 (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_start,
  output logic                 o_busy,
  output logic                 o_done,
  input  bilin_fix_pkg::dim_t  i_in_w,
  input  bilin_fix_pkg::dim_t  i_in_h,
  input  bilin_fix_pkg::q88_t  i_scale_q88,
  output bilin_fix_pkg::dim_t  o_out_w,
  output bilin_fix_pkg::dim_t  o_out_h,
  output bilin_fix_pkg::addr_t o_in_raddr,
  input  bilin_fix_pkg::pix_t  i_in_rdata,
  output bilin_fix_pkg::addr_t o_out_waddr,
  output bilin_fix_pkg::pix_t  o_out_wdata,
  output logic                 o_out_we,
  output bilin_fix_pkg::cnt_t  o_mem_rd_count,
  output bilin_fix_pkg::cnt_t  o_mem_wr_count
);
  import bilin_fix_pkg::*;
  import bilin_ctl_pkg::*;

  // Sequencer to blend controls
  logic      blend_cap;
  tap_sel_t  blend_tap;
  lane_idx_t blend_lane;
  logic      blend_mul;
  pix_t      blend_pix [`BILIN_LANES];

  geom_if geom ();

  assign o_out_w = geom.out_w;
  assign o_out_h = geom.out_h;

  coord_gen u_coord_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_in_w      (i_in_w),
    .i_in_h      (i_in_h),
    .i_scale_q88 (i_scale_q88),
    .geom        (geom)
  );

  tap_sequencer u_tap_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .i_in_w      (i_in_w),
    .geom        (geom),
    .o_in_raddr  (o_in_raddr),
    .o_cap       (blend_cap),
    .o_tap_sel   (blend_tap),
    .o_lane_idx  (blend_lane),
    .o_mul       (blend_mul),
    .i_pix       (blend_pix),
    .o_out_waddr (o_out_waddr),
    .o_out_wdata (o_out_wdata),
    .o_out_we    (o_out_we),
    .o_rd_count  (o_mem_rd_count),
    .o_wr_count  (o_mem_wr_count)
  );

  // Fractions come straight from the coordinate registers
  lane_blend u_lane_blend (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_cap      (blend_cap),
    .i_tap_sel  (blend_tap),
    .i_lane_idx (blend_lane),
    .i_rdata    (i_in_rdata),
    .i_mul      (blend_mul),
    .i_fx       (geom.frac_x),
    .i_fy       (geom.frac_y),
    .o_pix      (blend_pix)
  );

endmodule

// ==== hdl/lane_blend.sv ====
`timescale 1ns/10ps
`include "bilin_cfg.svh"

module lane_blend (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_cap,
  input  bilin_ctl_pkg::tap_sel_t  i_tap_sel,
  input  bilin_ctl_pkg::lane_idx_t i_lane_idx,
  input  bilin_fix_pkg::pix_t      i_rdata,
  input  logic                     i_mul,
  input  bilin_fix_pkg::frac_t     i_fx [`BILIN_LANES],
  input  bilin_fix_pkg::frac_t     i_fy,
  output bilin_fix_pkg::pix_t      o_pix [`BILIN_LANES]
);
  import bilin_fix_pkg::*;

  localparam int      LANES   = `BILIN_LANES;
  localparam int      TAPS    = 4;
  localparam weight_t ONE_Q08 = weight_t'(`BILIN_ONE_Q08);
  localparam acc_t    ROUND   = acc_t'(`BILIN_ROUND);

  // Indexed [lane][tap], tap in tap_sel_t encoding
  pix_t    taps [LANES][TAPS];
  weight_t wx   [LANES][2];
  weight_t wy   [2];
  wprod_t  w2d  [LANES][TAPS];
  acc_t    prod [LANES][TAPS];
  acc_t    sum  [LANES];

  // Tap capture, one lane per data cycle
  always_ff @(posedge clk) begin
    if (i_cap) begin
      taps[i_lane_idx][i_tap_sel] <= i_rdata;
    end
  end

  // --------------------------------------------------
  // Weights
  // --------------------------------------------------
  assign wy[0] = ONE_Q08 - {1'b0, i_fy};
  assign wy[1] = {1'b0, i_fy};

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    assign wx[k][0] = ONE_Q08 - {1'b0, i_fx[k]};
    assign wx[k][1] = {1'b0, i_fx[k]};

    // Tap bit 0 picks the x weight, bit 1 the y weight
    for (genvar t = 0; t < TAPS; t++) begin : g_tap
      assign w2d[k][t] = wx[k][t % 2] * wy[t / 2];
    end

    // Sum in Q8.16, round, keep the integer byte
    assign sum[k]   = prod[k][0] + prod[k][1] + prod[k][2] + prod[k][3] + ROUND;
    assign o_pix[k] = sum[k][23:16];
  end

  // --------------------------------------------------
  // Products, all sixteen in the multiply cycle
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < LANES; k++) begin
        for (int t = 0; t < TAPS; t++) begin
          prod[k][t] <= '0;
        end
      end
    end else if (i_mul) begin
      for (int k = 0; k < LANES; k++) begin
        for (int t = 0; t < TAPS; t++) begin
          prod[k][t] <= acc_t'(w2d[k][t]) * acc_t'(taps[k][t]);
        end
      end
    end
  end

endmodule

// ==== hdl/tap_sequencer.sv ====
`timescale 1ns/10ps
`include "bilin_cfg.svh"

module tap_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_start,
  output logic                     o_busy,
  output logic                     o_done,
  input  bilin_fix_pkg::dim_t      i_in_w,
  geom_if.seq                      geom,
  output bilin_fix_pkg::addr_t     o_in_raddr,
  output logic                     o_cap,
  output bilin_ctl_pkg::tap_sel_t  o_tap_sel,
  output bilin_ctl_pkg::lane_idx_t o_lane_idx,
  output logic                     o_mul,
  input  bilin_fix_pkg::pix_t      i_pix [`BILIN_LANES],
  output bilin_fix_pkg::addr_t     o_out_waddr,
  output bilin_fix_pkg::pix_t      o_out_wdata,
  output logic                     o_out_we,
  output bilin_fix_pkg::cnt_t      o_rd_count,
  output bilin_fix_pkg::cnt_t      o_wr_count
);
  import bilin_fix_pkg::*;
  import bilin_ctl_pkg::*;

  seq_state_t state;
  seq_state_t state_n;
  tap_sel_t   tap;
  lane_idx_t  lane_idx;
  // Lane whose read address is registered in this cycle
  lane_idx_t  rd_lane;
  logic       rd_load;
  lane_idx_t  wr_lane;
  logic       in_write;

  // Row-major address of pixel (x, y)
  function automatic addr_t linaddr(dim_t x, dim_t y, dim_t width);
    logic [31:0] lin;
    lin = y * width + x;
    return lin[`BILIN_AW-1:0];
  endfunction

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_n = state;
    case (state)
      S_IDLE: begin
        if (i_start) begin
          state_n = S_INIT;
        end
      end
      S_INIT:        state_n = S_ROW_INIT;
      S_ROW_INIT:    state_n = S_GROUP_SETUP;
      S_GROUP_SETUP: state_n = S_TAP_INIT;
      S_TAP_INIT:    state_n = S_TAP_WAIT;
      S_TAP_WAIT:    state_n = S_TAP_DATA;
      S_TAP_DATA: begin
        // Last lane of a phase, next tap or on to the multiply
        if (lane_idx == 2'd3) begin
          state_n = (tap == TAP_11) ? S_MUL : S_TAP_INIT;
        end
      end
      S_MUL:         state_n = S_WRITE0;
      S_WRITE0:      state_n = S_WRITE1;
      S_WRITE1:      state_n = S_WRITE2;
      S_WRITE2:      state_n = S_WRITE3;
      S_WRITE3:      state_n = S_NEXT_GROUP;
      S_NEXT_GROUP:  state_n = geom.last_group ? S_NEXT_ROW : S_GROUP_SETUP;
      S_NEXT_ROW:    state_n = geom.last_row ? S_DONE : S_ROW_INIT;
      S_DONE:        state_n = S_IDLE;
      default:       state_n = S_IDLE;
    endcase
  end

  // Read address runs one lane ahead of the capture
  // The memory answers one cycle later, so lane k is read while lane k-1 is captured
  always_comb begin
    rd_load = 1'b1;
    rd_lane = 2'd0;
    case (state)
      S_TAP_INIT: rd_lane = 2'd0;
      S_TAP_WAIT: rd_lane = 2'd1;
      S_TAP_DATA: begin
        rd_lane = lane_idx + 2'd2;
        rd_load = (lane_idx < 2'd2);
      end
      default: rd_load = 1'b0;
    endcase
  end

  // One write slot per lane
  always_comb begin
    in_write = 1'b1;
    wr_lane  = 2'd0;
    case (state)
      S_WRITE0: wr_lane = 2'd0;
      S_WRITE1: wr_lane = 2'd1;
      S_WRITE2: wr_lane = 2'd2;
      S_WRITE3: wr_lane = 2'd3;
      default:  in_write = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Strobes to the coordinate generator and the blend
  // --------------------------------------------------
  assign geom.load_dims   = (state == S_IDLE) && i_start;
  assign geom.row_init    = (state == S_ROW_INIT);
  assign geom.group_setup = (state == S_GROUP_SETUP);
  assign geom.group_next  = (state == S_NEXT_GROUP);
  assign geom.row_next    = (state == S_NEXT_ROW);

  assign o_cap      = (state == S_TAP_DATA);
  assign o_tap_sel  = tap;
  assign o_lane_idx = lane_idx;
  assign o_mul      = (state == S_MUL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      tap        <= TAP_00;
      lane_idx   <= '0;
      o_busy     <= 1'b0;
      o_done     <= 1'b0;
      o_out_we   <= 1'b0;
      o_rd_count <= '0;
      o_wr_count <= '0;
    end else begin
      state    <= state_n;
      o_done   <= (state == S_DONE);
      o_out_we <= in_write && geom.valid[wr_lane];

      // Busy from the first cycle after setup until done
      if (state == S_INIT) begin
        o_busy <= 1'b1;
      end else if (state == S_DONE) begin
        o_busy <= 1'b0;
      end

      // Only lanes inside the output row are counted
      if (geom.load_dims) begin
        o_rd_count <= '0;
        o_wr_count <= '0;
      end else begin
        if (o_cap && geom.valid[lane_idx]) begin
          o_rd_count <= o_rd_count + 32'd1;
        end
        if (in_write && geom.valid[wr_lane]) begin
          o_wr_count <= o_wr_count + 32'd1;
        end
      end

      case (state)
        S_GROUP_SETUP: tap <= TAP_00;
        S_TAP_INIT:    lane_idx <= '0;
        S_TAP_DATA: begin
          lane_idx <= lane_idx + 2'd1;
          if (lane_idx == 2'd3) begin
            tap <= tap_sel_t'(tap + 2'd1);
          end
        end
        default: ;
      endcase
    end
  end

  // Memory address and write data
  always_ff @(posedge clk) begin
    if (rd_load) begin
      o_in_raddr <= linaddr(geom.base_x[rd_lane] + dim_t'(tap[0]),
                            geom.base_y + dim_t'(tap[1]), i_in_w);
    end
    if (in_write) begin
      o_out_waddr <= linaddr(geom.lane_x0 + dim_t'(wr_lane), geom.row, geom.out_w);
      o_out_wdata <= i_pix[wr_lane];
    end
  end

endmodule

// ==== hdl/coord_gen.sv ====
`timescale 1ns/10ps
`include "bilin_cfg.svh"

module coord_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  bilin_fix_pkg::dim_t i_in_w,
  input  bilin_fix_pkg::dim_t i_in_h,
  input  bilin_fix_pkg::q88_t i_scale_q88,
  geom_if.gen                 geom
);
  import bilin_fix_pkg::*;

  localparam int LANES = `BILIN_LANES;

  logic [31:0] mul_w;
  logic [31:0] mul_h;
  q88_t        inv_scale_nxt;
  q88_t        inv_scale;
  q168_t       inv_ext;
  dim_t        group_x;
  q168_t       sy_acc;
  q168_t       sx_acc;
  q168_t       sx_lane   [LANES];
  q168_t       x_clamped [LANES];
  q168_t       y_clamped;

  // Past the last full interval the base sticks at dim-2 with the fraction at max
  function automatic q168_t clamp_coord(q168_t coord, dim_t dim);
    q168_t res;
    if (coord[23:8] >= dim - 16'd1) begin
      res = {dim - 16'd2, 8'hFF};
    end else begin
      res = coord;
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Frame geometry
  // --------------------------------------------------
  assign mul_w         = i_in_w * i_scale_q88;
  assign mul_h         = i_in_h * i_scale_q88;
  // floor(65536 / scale) gives 1/scale in Q8.8
  assign inv_scale_nxt = q88_t'(32'd65536 / {16'd0, i_scale_q88});
  assign inv_ext       = {8'd0, inv_scale};

  // --------------------------------------------------
  // Source coordinates
  // --------------------------------------------------
  assign y_clamped = clamp_coord(sy_acc, i_in_h);

  // Lane k sits k inverse-scale steps right of the group origin
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    assign sx_lane[g]   = sx_acc + inv_ext * q168_t'(g);
    assign x_clamped[g] = clamp_coord(sx_lane[g], i_in_w);
  end

  assign geom.last_group = (group_x + dim_t'(LANES)) >= geom.out_w;
  assign geom.last_row   = (geom.row + 16'd1) >= geom.out_h;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      geom.out_w   <= '0;
      geom.out_h   <= '0;
      inv_scale    <= '0;
      geom.row     <= '0;
      sy_acc       <= '0;
      group_x      <= '0;
      sx_acc       <= '0;
      geom.lane_x0 <= '0;
      geom.valid   <= '0;
    end else begin
      // Start of frame, top row
      if (geom.load_dims) begin
        geom.out_w <= mul_w[23:8];
        geom.out_h <= mul_h[23:8];
        inv_scale  <= inv_scale_nxt;
        geom.row   <= '0;
        sy_acc     <= '0;
      end
      // Start of row, leftmost group
      if (geom.row_init) begin
        group_x <= '0;
        sx_acc  <= '0;
      end
      if (geom.group_setup) begin
        geom.lane_x0 <= group_x;
        for (int k = 0; k < LANES; k++) begin
          geom.valid[k] <= (group_x + dim_t'(k)) < geom.out_w;
        end
      end
      // Four output pixels move the source x by four steps
      if (geom.group_next) begin
        group_x <= group_x + dim_t'(LANES);
        sx_acc  <= sx_acc + (inv_ext << 2);
      end
      if (geom.row_next) begin
        geom.row <= geom.row + 16'd1;
        sy_acc   <= sy_acc + inv_ext;
      end
    end
  end

  // Clamped coordinates, held for the whole row or group
  always_ff @(posedge clk) begin
    if (geom.row_init) begin
      geom.base_y <= y_clamped[23:8];
      geom.frac_y <= y_clamped[7:0];
    end
    if (geom.group_setup) begin
      for (int k = 0; k < LANES; k++) begin
        geom.base_x[k] <= x_clamped[k][23:8];
        geom.frac_x[k] <= x_clamped[k][7:0];
      end
    end
  end

endmodule

// ==== hdl/geom_if.sv ====
`timescale 1ns/10ps
`include "bilin_cfg.svh"

interface geom_if;
  import bilin_fix_pkg::*;

  // Strobes from the sequencer, one cycle each
  logic load_dims;
  logic row_init;
  logic group_setup;
  logic group_next;
  logic row_next;

  // Frame geometry
  dim_t out_w;
  dim_t out_h;

  // Per-lane clamped source x of the current group
  dim_t  base_x [`BILIN_LANES];
  frac_t frac_x [`BILIN_LANES];

  // Clamped source y of the current row, shared by all lanes
  dim_t  base_y;
  frac_t frac_y;

  // Output position of the group
  logic [`BILIN_LANES-1:0] valid;
  dim_t                    lane_x0;
  dim_t                    row;

  // Loop exit flags
  logic last_group;
  logic last_row;

  modport gen (
    input  load_dims, row_init, group_setup, group_next, row_next,
    output out_w, out_h, base_x, frac_x, base_y, frac_y,
    output valid, lane_x0, row, last_group, last_row
  );

  modport seq (
    output load_dims, row_init, group_setup, group_next, row_next,
    input  out_w, out_h, base_x, frac_x, base_y, frac_y,
    input  valid, lane_x0, row, last_group, last_row
  );

endinterface

// ==== hdl/bilin_ctl_pkg.sv ====
package bilin_ctl_pkg;

  // Sequencer states
  // A tap phase is INIT, WAIT and four DATA cycles, repeated per tap
  typedef enum logic [4:0] {
    S_IDLE        = 5'd0,
    S_INIT        = 5'd1,
    S_ROW_INIT    = 5'd2,
    S_GROUP_SETUP = 5'd3,
    S_TAP_INIT    = 5'd4,
    S_TAP_WAIT    = 5'd5,
    S_TAP_DATA    = 5'd6,
    S_MUL         = 5'd7,
    S_WRITE0      = 5'd8,
    S_WRITE1      = 5'd9,
    S_WRITE2      = 5'd10,
    S_WRITE3      = 5'd11,
    S_NEXT_GROUP  = 5'd12,
    S_NEXT_ROW    = 5'd13,
    S_DONE        = 5'd14
  } seq_state_t;

  typedef logic [1:0] lane_idx_t;

  // Bit 0 is the x offset, bit 1 the y offset of the neighbour
  typedef enum logic [1:0] {
    TAP_00 = 2'b00,
    TAP_10 = 2'b01,
    TAP_01 = 2'b10,
    TAP_11 = 2'b11
  } tap_sel_t;

endpackage

// ==== hdl/bilin_fix_pkg.sv ====
`include "bilin_cfg.svh"

package bilin_fix_pkg;

  // Image dimension or integer pixel index
  typedef logic [15:0] dim_t;

  // Scale and inverse scale in Q8.8
  typedef logic [15:0] q88_t;

  // Accumulated source coordinate, integer part in 23:8
  typedef logic [23:0] q168_t;

  // Fractional part of a source coordinate
  typedef logic [7:0] frac_t;

  // One-dimensional weight, 9 bits so that 1.0 fits
  typedef logic [8:0] weight_t;

  // Two-dimensional weight in Q0.16
  typedef logic [17:0] wprod_t;

  // Weighted tap or sum of taps in Q8.16
  typedef logic [31:0] acc_t;

  typedef logic [7:0] pix_t;

  typedef logic [`BILIN_AW-1:0] addr_t;

  // Read and write counters
  typedef logic [31:0] cnt_t;

endpackage

// ==== hdl/bilin_cfg.svh ====
`ifndef BILIN_CFG_SVH
`define BILIN_CFG_SVH

// Memory address width, covers frames of up to 512K pixels
`define BILIN_AW 19

// Pixels processed per group
`define BILIN_LANES 4

// 1.0 in Q0.8
`define BILIN_ONE_Q08 256

// Half an LSB of the 8-bit result in the Q8.16 sum
`define BILIN_ROUND 32'h0000_8000

`endif
